//--- compile.f
+incdir+.
periph_pkg.sv
payload_fifo.sv
ps2_receiver.sv
spi_flash_reader.sv
periph_ctrl.sv
board_periph_top.sv
board_periph_props.sv
tb_board_periph.sv

//--- Makefile
SIM      = verilator
TOP      = tb_board_periph
FILELIST = compile.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
LINT     = --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- tb_board_periph.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module tb_board_periph import periph_pkg::*; ();

  // Keyboard bit timing in system clocks
  localparam int ps2_half     = 40;
  localparam int ps2_gap      = 40;
  localparam int frame_cycles = 11 * 2 * ps2_half + ps2_gap;
  localparam int n_frames     = 25;
  // Short request, long request, busy-write request
  localparam int max_flash_bytes = 16 + 48 + 16;
  localparam int sck_ns          = 2 * `PERIPH_SPI_HALF * 20;
  localparam longint budget_ns   = longint'(n_frames) * frame_cycles * 20
                                 + longint'(max_flash_bytes) * 20 * sck_ns + 200_000;

  typedef enum {k_word, k_ps2, k_flash, k_none} check_kind_t;

  typedef struct {
    check_kind_t kind;
    logic [31:0] exp;
    logic [31:0] got;
    logic [1:0]  exp_resp;
    logic [1:0]  got_resp;
    string       what;
  } check_t;

  logic        CLK_16mhz;
  logic        pll_locked;
  axil_m2s_t   m2s;
  axil_s2m_t   s2m;
  logic        kbd_clock;
  logic        kbd_data;
  spi_pins_t   spi;
  logic        miso;
  logic        led;
  logic [31:0] lfsr_state;
  int          error_count = 0;
  check_t      checks[$];

  board_periph_top UUT (
    .CLK_16mhz      (CLK_16mhz),
    .pll_locked     (pll_locked),
    .bus_in         (m2s),
    .bus_out        (s2m),
    .keyboard_clock (kbd_clock),
    .keyboard_data  (kbd_data),
    .spi            (spi),
    .miso           (miso),
    .led            (led)
  );

  bind board_periph_top board_periph_props u_props (
    .CLK_16mhz (CLK_16mhz),
    .rst_n     (rst_n),
    .bus_in    (bus_in),
    .bus_out   (bus_out),
    .spi       (spi)
  );

  // 50 MHz-style 20 ns period
  initial begin
    CLK_16mhz = 1'b0;
    forever #10 CLK_16mhz = ~CLK_16mhz;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "run stopped at first failure");
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  // Expected values from the register map
  function automatic logic [7:0] expected_flash_byte(input logic [23:0] addr);
    return addr[7:0] ^ 8'hA5 ^ addr[15:8];
  endfunction

  function automatic logic [31:0] ps2_reg_value(input logic [7:0] code, input logic bad);
    return {23'd0, bad, code};
  endfunction

  function automatic logic [1:0] expected_resp(input logic [7:0] offset, input logic is_write);
    logic ok;
    case (offset)
      `REG_STATUS, `REG_FLASH_ADDR, `REG_LED: ok = 1'b1;
      `REG_PS2_DATA, `REG_FLASH_DATA: ok = !is_write;
      `REG_FLASH_LEN: ok = is_write;
      default: ok = 1'b0;
    endcase
    return ok ? `PERIPH_RESP_OKAY : `PERIPH_RESP_SLVERR;
  endfunction

  task automatic compare_resp(input logic [1:0] exp, input logic [1:0] got, input string what);
    if (got !== exp) begin
      error_count++;
      stop_with_failure($sformatf("[ERROR] %0t ns: %s resp %02b, expected %02b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic compare_word(input logic [31:0] exp, input logic [31:0] got, input string what);
    if (got !== exp) begin
      error_count++;
      stop_with_failure($sformatf("[ERROR] %0t ns: %s read %08h, expected %08h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic compare_ps2(input ps2_code_t exp, input ps2_code_t got, input string what);
    if (got !== exp) begin
      error_count++;
      stop_with_failure($sformatf("[ERROR] %0t ns: %s code %02h perr %0b, expected %02h perr %0b",
                                  $time, what, got.code, got.parity_err, exp.code, exp.parity_err));
    end
  endtask

  task automatic compare_flash(input flash_byte_t exp, input flash_byte_t got, input string what);
    if (got !== exp) begin
      error_count++;
      stop_with_failure($sformatf("[ERROR] %0t ns: %s byte %02h last %0b, expected %02h last %0b",
                                  $time, what, got.data, got.last, exp.data, exp.last));
    end
  endtask

  // Drains queued results on each clock
  initial begin : compare
    check_t c;
    forever begin
      @(posedge CLK_16mhz);
      while (checks.size() != 0) begin
        c = checks.pop_front();
        compare_resp(c.exp_resp, c.got_resp, c.what);
        case (c.kind)
          k_word: compare_word(c.exp, c.got, c.what);
          k_ps2: begin
            compare_ps2(ps2_code_t'(c.exp[8:0]), ps2_code_t'(c.got[8:0]), c.what);
            compare_word(c.exp & 32'hFFFF_FE00, c.got & 32'hFFFF_FE00, c.what);
          end
          k_flash: begin
            compare_flash(flash_byte_t'(c.exp[8:0]), flash_byte_t'(c.got[8:0]), c.what);
            compare_word(c.exp & 32'hFFFF_FE00, c.got & 32'hFFFF_FE00, c.what);
          end
          default: ;
        endcase
      end
    end
  end

  task automatic add_check(input check_kind_t kind, input logic [31:0] exp, input logic [31:0] got,
                           input logic [1:0] exp_resp, input logic [1:0] got_resp,
                           input string what);
    checks.push_back('{kind, exp, got, exp_resp, got_resp, what});
  endtask

  // Inputs change 2 ns after the edge
  task automatic step();
    @(posedge CLK_16mhz);
    #2;
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int delay;
    step();
    m2s.awvalid = 1'b1;
    m2s.awaddr  = addr;
    m2s.wvalid  = 1'b1;
    m2s.wdata   = data;
    m2s.wstrb   = strb;
    @(negedge CLK_16mhz);
    while (!s2m.awready && !s2m.wready) @(negedge CLK_16mhz);
    // Address and data ready rise together
    if (s2m.awready !== s2m.wready)
      stop_with_failure($sformatf("[ERROR] %0t ns: awready %0b and wready %0b differ",
                                  $time, s2m.awready, s2m.wready));
    step();
    m2s.awvalid = 1'b0;
    m2s.wvalid  = 1'b0;
    delay = int'(rand_bits(2));
    repeat (delay) step();
    m2s.bready = 1'b1;
    @(negedge CLK_16mhz);
    while (!s2m.bvalid) @(negedge CLK_16mhz);
    resp = s2m.bresp;
    step();
    m2s.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int delay;
    step();
    m2s.arvalid = 1'b1;
    m2s.araddr  = addr;
    @(negedge CLK_16mhz);
    while (!s2m.arready) @(negedge CLK_16mhz);
    step();
    m2s.arvalid = 1'b0;
    delay = int'(rand_bits(2));
    repeat (delay) step();
    m2s.rready = 1'b1;
    @(negedge CLK_16mhz);
    while (!s2m.rvalid) @(negedge CLK_16mhz);
    data = s2m.rdata;
    resp = s2m.rresp;
    step();
    m2s.rready = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input check_kind_t kind,
                            input logic [31:0] exp, input string what);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    add_check(kind, exp, data, expected_resp(addr, 1'b0), resp, what);
  endtask

  task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input string what);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    add_check(k_none, '0, '0, expected_resp(addr, 1'b1), resp, what);
  endtask

  // Poll STATUS until one bit reaches a value
  task automatic wait_status(input int bit_idx, input logic value);
    logic [31:0] data;
    logic [1:0]  resp;
    do axi_read(`REG_STATUS, data, resp); while (data[bit_idx] !== value);
  endtask

  // Keyboard side: data set mid high phase, sampled on falling clock
  task automatic send_frame(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      step();
      kbd_data = frame[i];
      repeat (ps2_half / 2 - 1) step();
      kbd_clock = 1'b0;
      repeat (ps2_half) step();
      kbd_clock = 1'b1;
      repeat (ps2_half / 2) step();
    end
    repeat (ps2_gap) step();
  endtask

  task automatic flash_request(input logic [23:0] addr, input logic [7:0] len);
    write_check(`REG_FLASH_ADDR, {8'd0, addr}, 4'hF, "FLASH_ADDR write");
    read_check(`REG_FLASH_ADDR, k_word, {8'd0, addr}, "FLASH_ADDR readback");
    write_check(`REG_FLASH_LEN, {24'd0, len}, 4'h1, "FLASH_LEN write");
  endtask

  // Reads until len bytes arrived, empty reads are retried
  task automatic drain_flash(input logic [23:0] addr, input int len);
    logic [31:0] data;
    logic [1:0]  resp;
    flash_byte_t exp;
    int          got;
    got = 0;
    while (got < len) begin
      axi_read(`REG_FLASH_DATA, data, resp);
      if (!data[31]) begin
        exp = '{last: (got == len - 1), data: expected_flash_byte(addr + 24'(got))};
        add_check(k_flash, {23'd0, exp}, data, `PERIPH_RESP_OKAY, resp, "FLASH_DATA");
        got++;
      end
    end
  endtask

  // SPI flash: opcode and address in, data out after falling SCK
  initial begin : flash_model
    logic [31:0] cmd_word;
    logic [23:0] addr;
    logic [7:0]  cur;
    int          nbits;
    int          idx;
    miso     = 1'b0;
    nbits    = 0;
    cmd_word = '0;
    forever begin
      @(spi.sck or spi.cs_n);
      if (spi.cs_n) begin
        nbits = 0;
      end else if (spi.sck) begin
        if (nbits < 32) cmd_word = {cmd_word[30:0], spi.mosi};
        nbits++;
        if (nbits == 8 && cmd_word[7:0] != 8'h03)
          stop_with_failure($sformatf("[ERROR] %0t ns: flash opcode %02h, expected 03",
                                      $time, cmd_word[7:0]));
      end else if (nbits >= 32) begin
        idx  = nbits - 32;
        addr = cmd_word[23:0] + 24'(idx / 8);
        cur  = addr[7:0] ^ 8'hA5 ^ addr[15:8];
        #2;
        miso = cur[7 - idx % 8];
      end
    end
  end

  initial begin : watchdog
    #(budget_ns);
    stop_with_failure($sformatf("Timeout: the test did not finish within %0d ns", budget_ns));
  end

  initial begin : stimulus
    logic [7:0]  code;
    logic [7:0]  codes[18];
    logic [23:0] addr;
    logic [7:0]  len;
    lfsr_state = 32'hb8557ae3;
    m2s        = '0;
    kbd_clock  = 1'b1;
    kbd_data   = 1'b1;
    pll_locked = 1'b0;
    repeat (10) step();
    pll_locked = 1'b1;
    repeat (5) step();

    // Idle state after reset
    read_check(`REG_STATUS, k_word, 32'h0, "STATUS after reset");
    read_check(`REG_LED, k_word, 32'h0, "LED after reset");
    read_check(`REG_PS2_DATA, k_word, 32'h8000_0000, "PS2_DATA empty");
    read_check(`REG_FLASH_DATA, k_word, 32'h8000_0000, "FLASH_DATA empty");

    // Scan codes one by one, last frame with bad parity
    for (int i = 0; i < 7; i++) begin
      code = 8'(rand_bits(8));
      send_frame(code, i == 6);
      wait_status(0, 1'b1);
      read_check(`REG_PS2_DATA, k_ps2, ps2_reg_value(code, i == 6), "PS2_DATA");
    end

    // Overrun the scan code FIFO
    for (int i = 0; i < 18; i++) begin
      codes[i] = 8'(rand_bits(8));
      send_frame(codes[i], 1'b0);
    end
    for (int i = 0; i < 16; i++)
      read_check(`REG_PS2_DATA, k_ps2, ps2_reg_value(codes[i], 1'b0), "PS2_DATA burst");
    read_check(`REG_STATUS, k_word, 32'h8, "STATUS overflow set");
    write_check(`REG_STATUS, 32'h8, 4'h1, "STATUS overflow clear");
    read_check(`REG_STATUS, k_word, 32'h0, "STATUS overflow cleared");

    // Short request, drained after busy falls
    addr = 24'(rand_bits(24));
    len  = 8'(1 + rand_bits(4));
    flash_request(addr, len);
    wait_status(1, 1'b0);
    drain_flash(addr, int'(len));

    // Long request stalls on the full FIFO
    addr = 24'(rand_bits(24));
    len  = 8'(17 + rand_bits(5));
    flash_request(addr, len);
    drain_flash(addr, int'(len));
    wait_status(1, 1'b0);

    // Second length write during a request is dropped
    addr = 24'(rand_bits(24));
    len  = 8'(1 + rand_bits(4));
    flash_request(addr, len);
    write_check(`REG_FLASH_LEN, 32'd40, 4'h1, "FLASH_LEN while busy");
    wait_status(1, 1'b0);
    drain_flash(addr, int'(len));
    read_check(`REG_FLASH_DATA, k_word, 32'h8000_0000, "FLASH_DATA after request");
    read_check(`REG_STATUS, k_word, 32'h0, "STATUS after request");

    // Register map responses and side effects
    write_check(`REG_LED, 32'h1, 4'h1, "LED write");
    read_check(`REG_LED, k_word, 32'h1, "LED readback");
    add_check(k_word, 32'h1, {31'd0, led}, 2'b00, 2'b00, "LED pin");
    // LED back to 0 so a stray write of bit 0 shows up
    write_check(`REG_LED, 32'h0, 4'h1, "LED clear");
    add_check(k_word, 32'h0, {31'd0, led}, 2'b00, 2'b00, "LED pin cleared");
    write_check(`REG_STATUS, 32'h1, 4'h1, "STATUS bit 0 write");
    write_check(`REG_PS2_DATA, 32'h1FF, 4'hF, "PS2_DATA write");
    write_check(`REG_FLASH_DATA, 32'h1FF, 4'hF, "FLASH_DATA write");
    write_check(8'h18, 32'hFFFF_FFFF, 4'hF, "unknown offset write");
    read_check(8'h18, k_none, 32'h0, "unknown offset read");
    read_check(`REG_FLASH_LEN, k_none, 32'h0, "FLASH_LEN read");
    read_check(`REG_PS2_DATA, k_word, 32'h8000_0000, "PS2_DATA still empty");
    read_check(`REG_STATUS, k_word, 32'h0, "STATUS unchanged");
    read_check(`REG_FLASH_ADDR, k_word, {8'd0, addr}, "FLASH_ADDR unchanged");
    read_check(`REG_LED, k_word, 32'h0, "LED unchanged");

    // Let the compare process catch up
    repeat (3) step();
    if (error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_with_failure("Checks failed during the run");
    end
  end

endmodule

//--- board_periph_props.sv
`timescale 1ns/1ns

module board_periph_props import periph_pkg::*; (
  input logic      CLK_16mhz,
  input logic      rst_n,
  input axil_m2s_t bus_in,
  input axil_s2m_t bus_out,
  input spi_pins_t spi
);

  // SCK idles low whenever the flash is deselected
  a_sck_idle: assert property (@(posedge CLK_16mhz) disable iff (!rst_n)
    spi.cs_n |-> !spi.sck)
    else $error("sck high while cs_n high");

  // Read data held until accepted
  a_rvalid_hold: assert property (@(posedge CLK_16mhz) disable iff (!rst_n)
    bus_out.rvalid && !bus_in.rready |=> bus_out.rvalid && $stable(bus_out.rdata))
    else $error("rvalid or rdata changed before rready");

  // Write response held until accepted
  a_bvalid_hold: assert property (@(posedge CLK_16mhz) disable iff (!rst_n)
    bus_out.bvalid && !bus_in.bready |=> bus_out.bvalid)
    else $error("bvalid dropped before bready");

  // Flash deselected as reset releases
  a_cs_reset: assert property (@(posedge CLK_16mhz)
    $rose(rst_n) |-> spi.cs_n && !spi.sck)
    else $error("cs_n low or sck high after reset");

endmodule

//--- board_periph_top.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module board_periph_top import periph_pkg::*; (
  input  logic      CLK_16mhz,
  input  logic      pll_locked,
  input  axil_m2s_t bus_in,
  output axil_s2m_t bus_out,
  input  logic      keyboard_clock,
  input  logic      keyboard_data,
  output spi_pins_t spi,
  input  logic      miso,
  output logic      led
);

  logic        rst_n;
  // Keyboard path
  logic        ps2_valid;
  logic        ps2_full;
  logic        ps2_pop;
  logic        ps2_empty;
  logic        ps2_overflow;
  ps2_code_t   ps2_code;
  ps2_code_t   ps2_head;
  // Flash path
  logic        flash_valid;
  logic        flash_full;
  logic        flash_pop;
  logic        flash_empty;
  logic        flash_start;
  logic        flash_busy;
  flash_byte_t flash_byte;
  flash_byte_t flash_head;
  flash_cmd_t  flash_cmd;

  // Reset sync and register map
  periph_ctrl u_ctrl (
    .CLK_16mhz    (CLK_16mhz),
    .pll_locked   (pll_locked),
    .rst_n        (rst_n),
    .bus_in       (bus_in),
    .bus_out      (bus_out),
    .ps2_pop      (ps2_pop),
    .ps2_head     (ps2_head),
    .ps2_empty    (ps2_empty),
    .ps2_overflow (ps2_overflow),
    .flash_pop    (flash_pop),
    .flash_head   (flash_head),
    .flash_empty  (flash_empty),
    .flash_start  (flash_start),
    .flash_cmd    (flash_cmd),
    .flash_busy   (flash_busy),
    .led          (led)
  );

  ps2_receiver u_ps2 (
    .CLK_16mhz      (CLK_16mhz),
    .rst_n          (rst_n),
    .keyboard_clock (keyboard_clock),
    .keyboard_data  (keyboard_data),
    .code_valid     (ps2_valid),
    .code           (ps2_code),
    .fifo_full      (ps2_full),
    .overflow       (ps2_overflow)
  );

  // Scan code buffer
  payload_fifo #(.payload_t(ps2_code_t), .depth(`PERIPH_FIFO_DEPTH)) ps2_fifo (
    .CLK_16mhz (CLK_16mhz),
    .rst_n     (rst_n),
    .push      (ps2_valid),
    .push_data (ps2_code),
    .full      (ps2_full),
    .pop       (ps2_pop),
    .head      (ps2_head),
    .empty     (ps2_empty)
  );

  spi_flash_reader u_flash (
    .CLK_16mhz  (CLK_16mhz),
    .rst_n      (rst_n),
    .start      (flash_start),
    .cmd        (flash_cmd),
    .busy       (flash_busy),
    .spi        (spi),
    .miso       (miso),
    .byte_valid (flash_valid),
    .rd_byte    (flash_byte),
    .fifo_full  (flash_full)
  );

  // Flash byte buffer
  payload_fifo #(.payload_t(flash_byte_t), .depth(`PERIPH_FIFO_DEPTH)) flash_fifo (
    .CLK_16mhz (CLK_16mhz),
    .rst_n     (rst_n),
    .push      (flash_valid),
    .push_data (flash_byte),
    .full      (flash_full),
    .pop       (flash_pop),
    .head      (flash_head),
    .empty     (flash_empty)
  );

endmodule

//--- periph_ctrl.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_ctrl import periph_pkg::*; (
  input  logic        CLK_16mhz,
  input  logic        pll_locked,
  output logic        rst_n,
  input  axil_m2s_t   bus_in,
  output axil_s2m_t   bus_out,
  output logic        ps2_pop,
  input  ps2_code_t   ps2_head,
  input  logic        ps2_empty,
  input  logic        ps2_overflow,
  output logic        flash_pop,
  input  flash_byte_t flash_head,
  input  logic        flash_empty,
  output logic        flash_start,
  output flash_cmd_t  flash_cmd,
  input  logic        flash_busy,
  output logic        led
);

  logic [2:0]  rst_chain;
  logic        wr_hs;
  logic        rd_hs;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        rvalid;
  logic [1:0]  rresp;
  logic [31:0] rdata;
  logic [23:0] flash_addr;
  logic [7:0]  flash_len;
  logic        overflow;
  logic [31:0] status_word;
  logic [31:0] ps2_word;
  logic [31:0] flash_word;

  // Three-stage reset synchronizer
  always_ff @(posedge CLK_16mhz or negedge pll_locked) begin
    if (!pll_locked) rst_chain <= '0;
    else rst_chain <= {rst_chain[1:0], 1'b1};
  end
  assign rst_n = rst_chain[2];

  // Address and data accepted together
  assign wr_hs = bus_in.awvalid && bus_in.wvalid && !bvalid;
  // One read outstanding
  assign rd_hs = bus_in.arvalid && !rvalid;

  assign bus_out = '{
    awready: wr_hs,
    wready:  wr_hs,
    bvalid:  bvalid,
    bresp:   bresp,
    arready: !rvalid,
    rvalid:  rvalid,
    rdata:   rdata,
    rresp:   rresp
  };

  // Pop on the read handshake of a non-empty data register
  assign ps2_pop   = rd_hs && (bus_in.araddr == `REG_PS2_DATA) && !ps2_empty;
  assign flash_pop = rd_hs && (bus_in.araddr == `REG_FLASH_DATA) && !flash_empty;

  assign flash_cmd   = '{address: flash_addr, count: flash_len};
  assign status_word = {28'd0, overflow, !flash_empty, flash_busy, !ps2_empty};
  // Bit 31 flags an empty FIFO
  assign ps2_word    = ps2_empty ? 32'h8000_0000 : {23'd0, ps2_head};
  assign flash_word  = flash_empty ? 32'h8000_0000 : {23'd0, flash_head};

  // Write channel and writable registers
  always_ff @(posedge CLK_16mhz or negedge rst_n) begin
    if (!rst_n) begin
      bvalid      <= 1'b0;
      bresp       <= `PERIPH_RESP_OKAY;
      flash_addr  <= '0;
      flash_len   <= '0;
      flash_start <= 1'b0;
      led         <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      flash_start <= 1'b0;
      if (bvalid && bus_in.bready) bvalid <= 1'b0;
      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp  <= `PERIPH_RESP_OKAY;
        case (bus_in.awaddr)
          // Write 1 to bit 3 clears overflow
          `REG_STATUS: begin
            if (bus_in.wstrb[0] && bus_in.wdata[3]) overflow <= 1'b0;
          end
          `REG_FLASH_ADDR: begin
            for (int i = 0; i < 3; i++) begin
              if (bus_in.wstrb[i]) flash_addr[8*i +: 8] <= bus_in.wdata[8*i +: 8];
            end
          end
          // Ignored while a request runs
          `REG_FLASH_LEN: begin
            if (bus_in.wstrb[0] && !flash_busy && !flash_start) begin
              flash_len   <= bus_in.wdata[7:0];
              flash_start <= 1'b1;
            end
          end
          `REG_LED: begin
            if (bus_in.wstrb[0]) led <= bus_in.wdata[0];
          end
          // Data registers are read-only
          default: bresp <= `PERIPH_RESP_SLVERR;
        endcase
      end
      // New overflow wins over a clear
      if (ps2_overflow) overflow <= 1'b1;
    end
  end

  // Read valid
  always_ff @(posedge CLK_16mhz or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (bus_in.rready) begin
      rvalid <= 1'b0;
    end
  end

  // Read data held until the next handshake
  always_ff @(posedge CLK_16mhz) begin
    if (rd_hs) begin
      rresp <= `PERIPH_RESP_OKAY;
      case (bus_in.araddr)
        `REG_STATUS:     rdata <= status_word;
        `REG_PS2_DATA:   rdata <= ps2_word;
        `REG_FLASH_ADDR: rdata <= {8'd0, flash_addr};
        `REG_FLASH_DATA: rdata <= flash_word;
        `REG_LED:        rdata <= {31'd0, led};
        // FLASH_LEN is write-only
        default: begin
          rdata <= '0;
          rresp <= `PERIPH_RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

//--- spi_flash_reader.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module spi_flash_reader import periph_pkg::*; (
  input  logic        CLK_16mhz,
  input  logic        rst_n,
  input  logic        start,
  input  flash_cmd_t  cmd,
  output logic        busy,
  output spi_pins_t   spi,
  input  logic        miso,
  output logic        byte_valid,
  output flash_byte_t rd_byte,
  input  logic        fifo_full
);

  localparam int half_len = `PERIPH_SPI_HALF;
  localparam int half_w   = $clog2(half_len + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_command,
    st_address,
    st_data,
    st_done
  } state_t;

  state_t            state;
  logic [half_w-1:0] half_cnt;
  logic              tick;
  logic              pause;
  logic              shifting;
  logic              rise;
  logic              cs_n;
  logic              sck;
  logic [31:0]       tx_shift;
  logic [7:0]        rx_shift;
  logic [7:0]        rx_next;
  logic [4:0]        bit_cnt;
  logic [8:0]        remaining;

  assign busy     = (state != st_idle);
  // Hold SCK low before the next byte while the FIFO has no room
  assign pause    = (state == st_data) && !sck && fifo_full;
  assign tick     = (half_cnt == half_w'(half_len - 1));
  assign shifting = (state == st_command) || (state == st_address) || (state == st_data);
  // Mode 0 sample point
  assign rise     = shifting && tick && !sck && !pause;
  assign rx_next  = {rx_shift[6:0], miso};
  assign spi      = '{cs_n: cs_n, sck: sck, mosi: tx_shift[31]};

  always_ff @(posedge CLK_16mhz or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      half_cnt   <= '0;
      cs_n       <= 1'b1;
      sck        <= 1'b0;
      tx_shift   <= '0;
      bit_cnt    <= '0;
      remaining  <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (state == st_idle) begin
        half_cnt <= '0;
        if (start) begin
          state     <= st_command;
          cs_n      <= 1'b0;
          // Read opcode then address MSB first
          tx_shift  <= {8'h03, cmd.address};
          bit_cnt   <= 5'd7;
          remaining <= {cmd.count == 8'd0, cmd.count};
        end
      end else if (!pause) begin
        if (!tick) begin
          half_cnt <= half_cnt + 1'b1;
        end else begin
          half_cnt <= '0;
          if (state == st_done) begin
            // Drop SCK then raise CS
            if (sck) begin
              sck <= 1'b0;
            end else begin
              cs_n       <= 1'b1;
              state      <= st_idle;
              // Last byte goes out as busy falls
              byte_valid <= 1'b1;
            end
          end else if (!sck) begin
            sck <= 1'b1;
            if (state == st_data && bit_cnt == 5'd0) begin
              if (remaining == 9'd1) state <= st_done;
              else byte_valid <= 1'b1;
            end
          end else begin
            sck      <= 1'b0;
            tx_shift <= {tx_shift[30:0], 1'b0};
            if (bit_cnt != 5'd0) begin
              bit_cnt <= bit_cnt - 1'b1;
            end else begin
              case (state)
                st_command: begin
                  state   <= st_address;
                  bit_cnt <= 5'd23;
                end
                st_address: begin
                  state   <= st_data;
                  bit_cnt <= 5'd7;
                end
                default: begin
                  bit_cnt   <= 5'd7;
                  remaining <= remaining - 1'b1;
                end
              endcase
            end
          end
        end
      end
    end
  end

  // Receive shifter and byte capture
  always_ff @(posedge CLK_16mhz) begin
    if (rise) begin
      rx_shift <= rx_next;
      if (state == st_data && bit_cnt == 5'd0) begin
        rd_byte <= '{last: remaining == 9'd1, data: rx_next};
      end
    end
  end

endmodule

//--- ps2_receiver.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module ps2_receiver import periph_pkg::*; (
  input  logic      CLK_16mhz,
  input  logic      rst_n,
  input  logic      keyboard_clock,
  input  logic      keyboard_data,
  output logic      code_valid,
  output ps2_code_t code,
  input  logic      fifo_full,
  output logic      overflow
);

  localparam int filt_len = `PERIPH_PS2_FILTER;
  localparam int filt_w   = $clog2(filt_len + 1);

  logic [1:0]        clk_sync;
  logic [1:0]        data_sync;
  logic              clk_filt;
  logic [filt_w-1:0] filt_cnt;
  logic              filt_done;
  logic              clk_fall;
  logic [3:0]        bit_cnt;
  logic [7:0]        shift;
  logic              parity_bit;

  // Filtered clock is about to switch
  assign filt_done = (clk_sync[1] != clk_filt) && (filt_cnt == filt_w'(filt_len - 1));
  // Accepted high to low transition
  assign clk_fall = filt_done && clk_filt;

  // Two-flop synchronizers and glitch filter
  always_ff @(posedge CLK_16mhz or negedge rst_n) begin
    if (!rst_n) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_filt  <= 1'b1;
      filt_cnt  <= '0;
    end else begin
      clk_sync  <= {clk_sync[0], keyboard_clock};
      data_sync <= {data_sync[0], keyboard_data};
      if (clk_sync[1] == clk_filt) begin
        filt_cnt <= '0;
      end else if (filt_done) begin
        clk_filt <= clk_sync[1];
        filt_cnt <= '0;
      end else begin
        filt_cnt <= filt_cnt + 1'b1;
      end
    end
  end

  // Frame deserializer
  always_ff @(posedge CLK_16mhz or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      code_valid <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      overflow   <= 1'b0;
      if (clk_fall) begin
        if (bit_cnt == 4'd0) begin
          // Wait for a low start bit
          if (!data_sync[1]) bit_cnt <= 4'd1;
        end else if (bit_cnt <= 4'd9) begin
          bit_cnt <= bit_cnt + 1'b1;
        end else begin
          bit_cnt <= 4'd0;
          // Stop bit must be high or the frame is dropped
          if (data_sync[1]) begin
            if (fifo_full) overflow <= 1'b1;
            else code_valid <= 1'b1;
          end
        end
      end
    end
  end

  // Data and parity capture
  always_ff @(posedge CLK_16mhz) begin
    if (clk_fall) begin
      // LSB first
      if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8) shift <= {data_sync[1], shift[7:1]};
      if (bit_cnt == 4'd9) parity_bit <= data_sync[1];
      // Odd parity over data plus parity bit
      if (bit_cnt == 4'd10) code <= '{parity_err: ~(^{shift, parity_bit}), code: shift};
    end
  end

endmodule

//--- payload_fifo.sv
`timescale 1ns/1ns

module payload_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 16
) (
  input  logic     CLK_16mhz,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t head,
  output logic     empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at depth so any depth works
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count == cnt_w'(depth));
  assign empty = (count == '0);
  // Overfill and underflow requests are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  // Show-ahead head
  assign head = mem[rd_ptr];

  always_ff @(posedge CLK_16mhz or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge CLK_16mhz) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

//--- periph_pkg.sv
package periph_pkg;

  // Master side of the AXI4-Lite bus
  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_m2s_t;

  // Slave side of the AXI4-Lite bus
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_s2m_t;

  // Parity flag sits above the code to match register bit 8
  typedef struct packed {
    logic       parity_err;
    logic [7:0] code;
  } ps2_code_t;

  // Last flag sits above the data to match register bit 8
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } flash_byte_t;

  // Count of zero means 256 bytes
  typedef struct packed {
    logic [23:0] address;
    logic [7:0]  count;
  } flash_cmd_t;

  typedef struct packed {
    logic cs_n;
    logic sck;
    logic mosi;
  } spi_pins_t;

endpackage

//--- periph_settings.svh
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Entries in each payload FIFO
`define PERIPH_FIFO_DEPTH 16

// System clocks per SCK half period
`define PERIPH_SPI_HALF 2

// Equal samples needed before a keyboard clock change counts
`define PERIPH_PS2_FILTER 4

// Register byte offsets on the AXI4-Lite bus
`define REG_STATUS     8'h00
`define REG_PS2_DATA   8'h04
`define REG_FLASH_ADDR 8'h08
`define REG_FLASH_LEN  8'h0C
`define REG_FLASH_DATA 8'h10
`define REG_LED        8'h14

// AXI response codes
`define PERIPH_RESP_OKAY   2'b00
`define PERIPH_RESP_SLVERR 2'b10

`endif
